//--- include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define CORE_DATA_WIDTH     32
`define CORE_REG_ADDR_WIDTH 4  // 16 registers
`define CORE_ID_WIDTH       7

// instruction ids decoded by this slice
`define ID_LSR_IMM   7'd1
`define ID_ASR_IMM   7'd2
`define ID_LSL_IMM   7'd3
`define ID_ADD_REG   7'd4
`define ID_ORR_REG   7'd5
`define ID_ADD_IMM   7'd6
`define ID_ORR_IMM   7'd7
`define ID_MOV_IMM   7'd8
`define ID_SUB_REG   7'd12
`define ID_LSR_REG   7'd14
`define ID_ASR_REG   7'd15
`define ID_LSL_REG   7'd16
`define ID_AND_REG   7'd17
`define ID_NOT_REG   7'd18
`define ID_ROR_REG   7'd19
`define ID_EOR_REG   7'd21
`define ID_ORR_TEST  7'd22  // no write
`define ID_ADD_TEST  7'd23  // no write
`define ID_BIC_REG   7'd24
`define ID_RSB_REG   7'd26
`define ID_MOV_SE8   7'd59
`define ID_MOV_SE12  7'd60
`define ID_HALT      7'd75

`endif

//--- hw/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

        typedef enum logic [3:0] {
                aluPassA = 4'd0,
                aluAnd   = 4'd1,
                aluAdd   = 4'd2,
                aluSub   = 4'd3,
                aluRsb   = 4'd4,  // b - a
                aluOrr   = 4'd5,
                aluEor   = 4'd6,
                aluBic   = 4'd7,
                aluNotB  = 4'd8,
                aluPassB = 4'd12
        } aluOp;

        typedef enum logic [3:0] {
                shiftNone = 4'd0,
                shiftLsl  = 4'd2,
                shiftLsr  = 4'd3,
                shiftAsr  = 4'd4,
                shiftRor  = 4'd5
        } shiftOp;

        typedef enum logic [2:0] {
                extZero12 = 3'd0,
                extSign8  = 3'd1,
                extSign12 = 3'd2
        } extendOp;

        typedef struct packed {
                aluOp    controlALU;
                shiftOp  controlBS;
                extendOp controlSE1;
                logic    controlMUX;  // 1 = immediate operand
                logic    controlRB;   // 1 = write rd
        } ctrlBundle;

        // rd = rn op (rm shifted)
        typedef struct packed {
                logic [`CORE_ID_WIDTH-1:0]       id;
                logic [`CORE_REG_ADDR_WIDTH-1:0] rd;
                logic [`CORE_REG_ADDR_WIDTH-1:0] rn;
                logic [`CORE_REG_ADDR_WIDTH-1:0] rm;
                logic [4:0]                      shamt;
                logic [7:0]                      spare;
        } regFormFields;

        // rd = rn op (imm extended and shifted)
        typedef struct packed {
                logic [`CORE_ID_WIDTH-1:0]       id;
                logic [`CORE_REG_ADDR_WIDTH-1:0] rd;
                logic [`CORE_REG_ADDR_WIDTH-1:0] rn;
                logic [4:0]                      shamt;
                logic [11:0]                     imm;
        } immFormFields;

        typedef union packed {
                regFormFields regForm;
                immFormFields immForm;
        } instrWord;

        typedef struct packed {
                logic [`CORE_DATA_WIDTH-1:0]     value;
                logic [`CORE_REG_ADDR_WIDTH-1:0] rd;
                logic                            written;
        } resultWord;

endpackage

//--- hw/controlCore.sv
`include "core_defs.svh"

module controlCore (
        input  logic [`CORE_ID_WIDTH-1:0] ID,
        output core_pkg::ctrlBundle       ctrl
);

        always_comb begin
                // pass b and write back unless the id says otherwise
                ctrl.controlALU = core_pkg::aluPassB;
                ctrl.controlBS  = core_pkg::shiftNone;
                ctrl.controlSE1 = core_pkg::extZero12;
                ctrl.controlMUX = 1'b0;
                ctrl.controlRB  = 1'b1;

                case (ID)
                        `ID_LSR_IMM: begin
                                ctrl.controlBS  = core_pkg::shiftLsr;
                                ctrl.controlMUX = 1'b1;
                        end
                        `ID_ASR_IMM: begin
                                ctrl.controlBS  = core_pkg::shiftAsr;
                                ctrl.controlMUX = 1'b1;
                        end
                        `ID_LSL_IMM: begin
                                ctrl.controlBS  = core_pkg::shiftLsl;
                                ctrl.controlMUX = 1'b1;
                        end
                        `ID_ADD_REG: begin
                                ctrl.controlALU = core_pkg::aluAdd;
                        end
                        `ID_ORR_REG: begin
                                ctrl.controlALU = core_pkg::aluOrr;
                        end
                        `ID_ADD_IMM: begin
                                ctrl.controlALU = core_pkg::aluAdd;
                                ctrl.controlMUX = 1'b1;
                        end
                        `ID_ORR_IMM: begin
                                ctrl.controlALU = core_pkg::aluOrr;
                                ctrl.controlMUX = 1'b1;
                        end
                        `ID_MOV_IMM: begin
                                ctrl.controlMUX = 1'b1;
                        end
                        `ID_SUB_REG: begin
                                ctrl.controlALU = core_pkg::aluSub;
                        end
                        `ID_LSR_REG: ctrl.controlBS = core_pkg::shiftLsr;
                        `ID_ASR_REG: ctrl.controlBS = core_pkg::shiftAsr;
                        `ID_LSL_REG: ctrl.controlBS = core_pkg::shiftLsl;
                        `ID_ROR_REG: ctrl.controlBS = core_pkg::shiftRor;
                        `ID_AND_REG: begin
                                ctrl.controlALU = core_pkg::aluAnd;
                        end
                        `ID_NOT_REG: begin
                                ctrl.controlALU = core_pkg::aluNotB;
                        end
                        `ID_EOR_REG: begin
                                ctrl.controlALU = core_pkg::aluEor;
                        end
                        `ID_ORR_TEST: begin
                                ctrl.controlALU = core_pkg::aluOrr;
                                ctrl.controlRB  = 1'b0;
                        end
                        `ID_ADD_TEST: begin
                                ctrl.controlALU = core_pkg::aluAdd;
                                ctrl.controlRB  = 1'b0;
                        end
                        `ID_BIC_REG: begin
                                ctrl.controlALU = core_pkg::aluBic;
                        end
                        `ID_RSB_REG: begin
                                ctrl.controlALU = core_pkg::aluRsb;
                        end
                        `ID_MOV_SE8: begin
                                ctrl.controlSE1 = core_pkg::extSign8;
                                ctrl.controlMUX = 1'b1;
                        end
                        `ID_MOV_SE12: begin
                                ctrl.controlSE1 = core_pkg::extSign12;
                                ctrl.controlMUX = 1'b1;
                        end
                        `ID_HALT: begin
                                ctrl.controlRB = 1'b0;  // halt flag itself is kept in resultStage
                        end
                        default: ctrl.controlRB = 1'b0;  // unknown id gives a result only
                endcase
        end

endmodule

//--- hw/operandShifter.sv
`include "core_defs.svh"

module operandShifter (
        input  logic [`CORE_DATA_WIDTH-1:0] regB,
        input  core_pkg::instrWord          instr,
        input  core_pkg::ctrlBundle         ctrl,
        output logic [`CORE_DATA_WIDTH-1:0] operand
);

        logic [`CORE_DATA_WIDTH-1:0]   immExt;
        logic [`CORE_DATA_WIDTH-1:0]   chosen;
        logic [4:0]                    shamt;
        logic [2*`CORE_DATA_WIDTH-1:0] rotWide;

        always_comb begin
                case (ctrl.controlSE1)
                        core_pkg::extSign8: begin
                                immExt = {{(`CORE_DATA_WIDTH-8){instr.immForm.imm[7]}},
                                          instr.immForm.imm[7:0]};
                        end
                        core_pkg::extSign12: begin
                                immExt = {{(`CORE_DATA_WIDTH-12){instr.immForm.imm[11]}},
                                          instr.immForm.imm};
                        end
                        default: immExt = {{(`CORE_DATA_WIDTH-12){1'b0}}, instr.immForm.imm};
                endcase
        end

        // shift amount sits in a different place per form
        assign chosen = ctrl.controlMUX ? immExt : regB;
        assign shamt  = ctrl.controlMUX ? instr.immForm.shamt : instr.regForm.shamt;

        assign rotWide = {chosen, chosen} >> shamt;  // low half is the rotation

        always_comb begin
                case (ctrl.controlBS)
                        core_pkg::shiftLsl: operand = chosen << shamt;
                        core_pkg::shiftLsr: operand = chosen >> shamt;
                        core_pkg::shiftAsr: operand = $signed(chosen) >>> shamt;
                        core_pkg::shiftRor: operand = rotWide[`CORE_DATA_WIDTH-1:0];
                        default:            operand = chosen;
                endcase
        end

endmodule

//--- hw/aluUnit.sv
`include "core_defs.svh"

module aluUnit (
        input  logic [`CORE_DATA_WIDTH-1:0] a,
        input  logic [`CORE_DATA_WIDTH-1:0] b,
        input  core_pkg::aluOp              op,
        output logic [`CORE_DATA_WIDTH-1:0] y
);

        // a is rn and b the shifted operand
        always_comb begin
                case (op)
                        core_pkg::aluPassA: y = a;
                        core_pkg::aluAnd:   y = a & b;
                        core_pkg::aluAdd:   y = a + b;  // wraps
                        core_pkg::aluSub:   y = a - b;
                        core_pkg::aluRsb:   y = b - a;
                        core_pkg::aluOrr:   y = a | b;
                        core_pkg::aluEor:   y = a ^ b;
                        core_pkg::aluBic:   y = a & ~b;
                        core_pkg::aluNotB:  y = ~b;
                        default:            y = b;  // pass b and unused codes
                endcase
        end

endmodule

//--- hw/registerBank.sv
`include "core_defs.svh"

module registerBank (
        input  logic                            clk,
        input  logic                            reset,
        input  logic [`CORE_REG_ADDR_WIDTH-1:0] readAddrA,
        input  logic [`CORE_REG_ADDR_WIDTH-1:0] readAddrB,
        input  logic                            writeEnable,
        input  logic [`CORE_REG_ADDR_WIDTH-1:0] writeAddr,
        input  logic [`CORE_DATA_WIDTH-1:0]     writeData,
        output logic [`CORE_DATA_WIDTH-1:0]     readDataA,
        output logic [`CORE_DATA_WIDTH-1:0]     readDataB
);

        localparam int RegCount = 2 ** `CORE_REG_ADDR_WIDTH;

        logic [`CORE_DATA_WIDTH-1:0] regs [RegCount];

        always_ff @(posedge clk) begin
                if (reset) begin
                        regs <= '{default: '0};
                end else if (writeEnable) begin
                        regs[writeAddr] <= writeData;
                end
        end

        // reads see the value before this edge's write
        assign readDataA = regs[readAddrA];
        assign readDataB = regs[readAddrB];

endmodule

//--- hw/executeCore.sv
`include "core_defs.svh"

module executeCore (
        input  logic                 clk,
        input  logic                 reset,
        input  logic                 issue,
        input  core_pkg::instrWord   instr,
        output core_pkg::resultWord  result,
        output logic                 resultValid,
        output logic                 halted
);

        core_pkg::ctrlBundle         ctrl;
        logic [`CORE_DATA_WIDTH-1:0] regA;
        logic [`CORE_DATA_WIDTH-1:0] regB;
        logic [`CORE_DATA_WIDTH-1:0] operand;
        logic [`CORE_DATA_WIDTH-1:0] aluResult;
        logic                        writeEnable;

        controlCore u_decode (
                .ID   (instr.regForm.id),
                .ctrl (ctrl)
        );

        registerBank u_regs (
                .clk         (clk),
                .reset       (reset),
                .readAddrA   (instr.regForm.rn),
                .readAddrB   (instr.regForm.rm),
                .writeEnable (writeEnable),
                .writeAddr   (instr.regForm.rd),
                .writeData   (aluResult),
                .readDataA   (regA),
                .readDataB   (regB)
        );

        operandShifter u_shift (
                .regB    (regB),
                .instr   (instr),
                .ctrl    (ctrl),
                .operand (operand)
        );

        aluUnit u_alu (
                .a  (regA),
                .b  (operand),
                .op (ctrl.controlALU),
                .y  (aluResult)
        );

        resultStage u_stage (
                .clk         (clk),
                .reset       (reset),
                .issue       (issue),
                .id          (instr.regForm.id),
                .rd          (instr.regForm.rd),
                .controlRB   (ctrl.controlRB),
                .aluResult   (aluResult),
                .writeEnable (writeEnable),
                .result      (result),
                .resultValid (resultValid),
                .halted      (halted)
        );

endmodule

module resultStage (
        input  logic                            clk,
        input  logic                            reset,
        input  logic                            issue,
        input  logic [`CORE_ID_WIDTH-1:0]       id,
        input  logic [`CORE_REG_ADDR_WIDTH-1:0] rd,
        input  logic                            controlRB,
        input  logic [`CORE_DATA_WIDTH-1:0]     aluResult,
        output logic                            writeEnable,
        output core_pkg::resultWord             result,
        output logic                            resultValid,
        output logic                            halted
);

        logic accepted;
        logic isHalt;

        assign accepted    = issue & ~halted;  // issues dropped once halted
        assign isHalt      = (id == `ID_HALT);
        assign writeEnable = accepted & controlRB & ~isHalt;

        always_ff @(posedge clk) begin
                if (reset) begin
                        resultValid <= 1'b0;
                        halted      <= 1'b0;
                end else begin
                        resultValid <= accepted & ~isHalt;
                        if (accepted & isHalt)
                                halted <= 1'b1;  // sticky until reset
                end
        end

        always_ff @(posedge clk) begin
                if (accepted & ~isHalt) begin
                        result.value   <= aluResult;
                        result.rd      <= rd;
                        result.written <= writeEnable;
                end
        end

endmodule

//--- verif/executeCoreTb.sv
`include "core_defs.svh"

module executeCoreTb;

        localparam int ClkPeriod     = 4;
        localparam int ResetCycles   = 4;
        localparam int RandomIssues  = 600;
        localparam int PlannedIssues = 16 + RandomIssues + 1 + 20 + 1;
        localparam int WatchdogTime  = (PlannedIssues * 3 + ResetCycles) * ClkPeriod;

        logic                clk;
        logic                reset;
        logic                issue;
        core_pkg::instrWord  instr;
        core_pkg::resultWord result;
        logic                resultValid;
        logic                halted;

        logic [31:0]         model [16];
        logic                modelHalted;
        logic                expectValid;
        core_pkg::resultWord expected;

        logic [6:0] tableIds [22] = '{`ID_LSR_IMM, `ID_ASR_IMM, `ID_LSL_IMM, `ID_ADD_REG,
                `ID_ORR_REG, `ID_ADD_IMM, `ID_ORR_IMM, `ID_MOV_IMM, `ID_SUB_REG, `ID_LSR_REG,
                `ID_ASR_REG, `ID_LSL_REG, `ID_AND_REG, `ID_NOT_REG, `ID_ROR_REG, `ID_EOR_REG,
                `ID_ORR_TEST, `ID_ADD_TEST, `ID_BIC_REG, `ID_RSB_REG, `ID_MOV_SE8, `ID_MOV_SE12};
        logic [6:0] spareIds [8] = '{7'd0, 7'd9, 7'd11, 7'd30, 7'd45, 7'd90, 7'd100, 7'd127};

        executeCore u_dut (
                .clk         (clk),
                .reset       (reset),
                .issue       (issue),
                .instr       (instr),
                .result      (result),
                .resultValid (resultValid),
                .halted      (halted)
        );

        always #(ClkPeriod / 2) clk = ~clk;

        initial begin
                #(WatchdogTime);
                $display("TESTS FAILED");
                $fatal(1, "watchdog expired before the run finished");
        end

        task automatic checkResult(input core_pkg::resultWord exp, input core_pkg::resultWord act);
                if (exp !== act) begin
                        $display("Error at %0t: result expected %h/%h/%b, got %h/%h/%b", $time,
                                 exp.value, exp.rd, exp.written, act.value, act.rd, act.written);
                        $display("TESTS FAILED");
                        $fatal(1, "result mismatch");
                end
        endtask

        task automatic checkValid(input bit exp, input logic act);
                if (act !== exp) begin
                        $display("Error at %0t: resultValid expected %b, got %b", $time, exp, act);
                        $display("TESTS FAILED");
                        $fatal(1, "resultValid mismatch");
                end
        endtask

        task automatic checkHalted(input bit exp, input logic act);
                if (act !== exp) begin
                        $display("Error at %0t: halted expected %b, got %b", $time, exp, act);
                        $display("TESTS FAILED");
                        $fatal(1, "halted mismatch");
                end
        endtask

        // reference model after the id table
        task automatic applyModel(input core_pkg::instrWord w);
                logic [9:0]  ctl;  // mux, bs, alu, rb
                logic        useImm;
                logic        wr;
                logic [3:0]  shiftCode;
                logic [3:0]  aluCode;
                logic [4:0]  amount;
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] y;

                if (w.regForm.id == `ID_HALT) begin
                        modelHalted = 1'b1;
                        return;
                end
                case (w.regForm.id)
                        `ID_ADD_REG:  ctl = {1'b0, 4'd0, 4'd2, 1'b1};
                        `ID_ADD_TEST: ctl = {1'b0, 4'd0, 4'd2, 1'b0};
                        `ID_ORR_REG:  ctl = {1'b0, 4'd0, 4'd5, 1'b1};
                        `ID_ORR_TEST: ctl = {1'b0, 4'd0, 4'd5, 1'b0};
                        `ID_SUB_REG:  ctl = {1'b0, 4'd0, 4'd3, 1'b1};
                        `ID_AND_REG:  ctl = {1'b0, 4'd0, 4'd1, 1'b1};
                        `ID_NOT_REG:  ctl = {1'b0, 4'd0, 4'd8, 1'b1};
                        `ID_EOR_REG:  ctl = {1'b0, 4'd0, 4'd6, 1'b1};
                        `ID_BIC_REG:  ctl = {1'b0, 4'd0, 4'd7, 1'b1};
                        `ID_RSB_REG:  ctl = {1'b0, 4'd0, 4'd4, 1'b1};
                        `ID_ADD_IMM:  ctl = {1'b1, 4'd0, 4'd2, 1'b1};
                        `ID_ORR_IMM:  ctl = {1'b1, 4'd0, 4'd5, 1'b1};
                        `ID_MOV_IMM, `ID_MOV_SE8, `ID_MOV_SE12: ctl = {1'b1, 4'd0, 4'd12, 1'b1};
                        `ID_LSR_IMM:  ctl = {1'b1, 4'd3, 4'd12, 1'b1};
                        `ID_ASR_IMM:  ctl = {1'b1, 4'd4, 4'd12, 1'b1};
                        `ID_LSL_IMM:  ctl = {1'b1, 4'd2, 4'd12, 1'b1};
                        `ID_LSR_REG:  ctl = {1'b0, 4'd3, 4'd12, 1'b1};
                        `ID_ASR_REG:  ctl = {1'b0, 4'd4, 4'd12, 1'b1};
                        `ID_LSL_REG:  ctl = {1'b0, 4'd2, 4'd12, 1'b1};
                        `ID_ROR_REG:  ctl = {1'b0, 4'd5, 4'd12, 1'b1};
                        default:      ctl = {1'b0, 4'd0, 4'd12, 1'b0};
                endcase
                {useImm, shiftCode, aluCode, wr} = ctl;
                a = model[w.regForm.rn];
                if (w.regForm.id == `ID_MOV_SE8)
                        b = {{24{w.immForm.imm[7]}}, w.immForm.imm[7:0]};
                else if (w.regForm.id == `ID_MOV_SE12)
                        b = {{20{w.immForm.imm[11]}}, w.immForm.imm};
                else
                        b = useImm ? {20'd0, w.immForm.imm} : model[w.regForm.rm];
                amount = useImm ? w.immForm.shamt : w.regForm.shamt;
                case (shiftCode)
                        4'd2: b = b << amount;
                        4'd3: b = b >> amount;
                        4'd4: b = $signed(b) >>> amount;
                        4'd5: b = (b >> amount) | (b << (32 - amount));
                        default: ;
                endcase
                case (aluCode)
                        4'd0: y = a;
                        4'd1: y = a & b;
                        4'd2: y = a + b;
                        4'd3: y = a - b;
                        4'd4: y = b - a;
                        4'd5: y = a | b;
                        4'd6: y = a ^ b;
                        4'd7: y = a & ~b;
                        4'd8: y = ~b;
                        default: y = b;
                endcase
                if (wr)
                        model[w.regForm.rd] = y;
                expected = '{value: y, rd: w.regForm.rd, written: wr};
                expectValid = 1'b1;
        endtask

        // check last cycle's outputs before driving the next
        task automatic step(input logic doIssue, input core_pkg::instrWord w);
                @(negedge clk);
                checkValid(expectValid, resultValid);
                if (expectValid)
                        checkResult(expected, result);
                checkHalted(modelHalted, halted);
                issue = doIssue;
                instr = w;
                expectValid = 1'b0;
                if (doIssue && !modelHalted)
                        applyModel(w);
        endtask

        function automatic core_pkg::instrWord randomInstr(input logic [6:0] id);
                core_pkg::instrWord w;

                w = $urandom();
                w.regForm.id = id;
                return w;
        endfunction

        initial begin
                core_pkg::instrWord w;
                logic [6:0]         id;

                void'($urandom(32'hac82));
                clk = 1'b0;
                reset = 1'b1;
                issue = 1'b0;
                instr = '0;
                modelHalted = 1'b0;
                expectValid = 1'b0;
                for (int i = 0; i < 16; i++)
                        model[i] = '0;
                repeat (ResetCycles) @(negedge clk);
                reset = 1'b0;

                // every register reads zero after reset
                for (int r = 0; r < 16; r++) begin
                        w = '0;
                        w.regForm.id = `ID_ADD_REG;
                        w.regForm.rd = r[3:0];
                        w.regForm.rn = r[3:0];
                        w.regForm.rm = r[3:0];
                        step(1'b1, w);
                end

                for (int n = 0; n < RandomIssues; n++) begin
                        if ($urandom_range(9) == 0)
                                id = spareIds[$urandom_range(7)];
                        else
                                id = tableIds[$urandom_range(21)];
                        step($urandom_range(99) < 70, randomInstr(id));
                end

                step(1'b1, randomInstr(`ID_HALT));
                for (int n = 0; n < 20; n++)
                        step(1'b1, randomInstr(tableIds[$urandom_range(21)]));
                step(1'b0, '0);

                $display("TESTS PASSED");
                $finish;
        end

endmodule

//--- list.f
+incdir+include
hw/core_pkg.sv
hw/controlCore.sv
hw/operandShifter.sv
hw/aluUnit.sv
hw/registerBank.sv
hw/executeCore.sv
verif/executeCoreTb.sv

//--- Bender.yml
package:
  name: execute_core

export_include_dirs:
  - include

sources:
  - files:
      - hw/core_pkg.sv
      - hw/controlCore.sv
      - hw/operandShifter.sv
      - hw/aluUnit.sv
      - hw/registerBank.sv
      - hw/executeCore.sv
  - target: test
    files:
      - verif/executeCoreTb.sv
